//--- hw/scaler_ctl.sv
/*
	Scaler register decoder
	Local bus access to the run bit and input frame size
*/

`timescale 1ns/1ps

module scaler_ctl
	import scaler_reg_pkg::*, scaler_video_pkg::*;
(
	input  logic             VID_CLK_IN,
	input  logic             rst_n,

	// Local bus
	input  logic             lb_wr,
	input  logic             lb_rd,
	input  logic [ADR_W-1:0] lb_adr,
	input  logic [DAT_W-1:0] lb_din,
	output logic [DAT_W-1:0] lb_dout,
	output logic             lb_vld,

	// Settings
	output logic             run,
	output logic [COL_W-1:0] h_in,
	output logic [ROW_W-1:0] v_in
);

	logic [DAT_W-1:0] h_lim;  // Clamped width
	logic [DAT_W-1:0] v_lim;  // Clamped height

	// Force size into 1..lim
	function automatic logic [DAT_W-1:0] clamp(input logic [DAT_W-1:0] val,
			input logic [DAT_W-1:0] lim);
		if (val == '0)
			clamp = 'd1;
		else if (val > lim)
			clamp = lim;
		else
			clamp = val;
	endfunction

	assign h_lim = clamp(lb_din, DAT_W'(MAX_W));
	assign v_lim = clamp(lb_din, DAT_W'(MAX_H));

	// Register writes
	always_ff @(posedge VID_CLK_IN or negedge rst_n)
	begin
		if (!rst_n)
		begin
			run  <= 1'b0;
			h_in <= COL_W'(MAX_W);
			v_in <= ROW_W'(MAX_H);
			lb_vld <= 1'b0;
		end
		else
		begin
			lb_vld <= lb_rd;  // Readback one clock after strobe
			if (lb_wr)
			begin
				case (lb_adr)
					ADR_W'(REG_CTL):  run  <= lb_din[CTL_RUN_BIT];
					ADR_W'(REG_H_IN): h_in <= h_lim[COL_W-1:0];
					ADR_W'(REG_V_IN): v_in <= v_lim[ROW_W-1:0];
					default: ;  // Unmapped, ignored
				endcase
			end
		end
	end

	// Readback mux
	always_ff @(posedge VID_CLK_IN)
	begin
		if (lb_rd)
		begin
			lb_dout <= '0;  // Unmapped reads as zero
			case (lb_adr)
				ADR_W'(REG_CTL):  lb_dout[CTL_RUN_BIT] <= run;
				ADR_W'(REG_H_IN): lb_dout <= DAT_W'(h_in);
				ADR_W'(REG_V_IN): lb_dout <= DAT_W'(v_in);
				default: ;
			endcase
		end
	end

	// Bus master must not overlap strobes
	a_lb_excl: assert property (@(posedge VID_CLK_IN) disable iff (!rst_n)
		!(lb_wr && lb_rd))
		else $error("lb_wr and lb_rd high together");

endmodule

//--- hw/scaler_hbs.sv
/*
	Horizontal bilinear scaler, one colour channel
	Emits each column and its average with the next one
*/

`timescale 1ns/1ps

module scaler_hbs
	import scaler_video_pkg::*;
(
	input  logic             VID_CLK_IN,
	input  logic             rst_n,
	input  logic             run,
	input  logic [COL_W-1:0] h_in,
	input  logic             hs_in,
	input  logic             de_in,
	input  logic [BPC-1:0]   dat_in,
	input  logic             vld_in,
	output logic             hs_out,
	output logic             de_out,
	output logic [BPC-1:0]   dat_out
);

	logic [BPC-1:0]   cur;    // Current column
	logic [BPC-1:0]   nxt;    // Next column
	logic [BPC:0]     sum;
	logic             ph;     // Output pixel parity
	logic [COL_W-1:0] scnt;   // Columns shifted in
	logic             shift;
	logic [4:0]       hs_sr;  // Sync delay to match data
	logic [4:0]       de_sr;

	// Extra shift after the last column repeats it
	assign shift = vld_in || (ph && scnt == h_in);
	assign sum   = {1'b0, cur} + {1'b0, nxt};

	always_ff @(posedge VID_CLK_IN or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ph <= 1'b0;
			scnt <= '0;
			hs_sr <= '0;
			de_sr <= '0;
		end
		else
		begin
			hs_sr <= run ? {hs_sr[3:0], hs_in} : 5'd0;
			de_sr <= run ? {de_sr[3:0], de_in} : 5'd0;
			ph <= hs_in ? 1'b0 : ~ph;  // Even phase starts with de
			if (hs_in)
				scnt <= '0;
			else if (shift)
				scnt <= scnt + 1'b1;
		end
	end

	// Column pair and output pixel
	always_ff @(posedge VID_CLK_IN)
	begin
		if (shift)
		begin
			cur <= nxt;
			if (vld_in)
				nxt <= dat_in;
		end
		dat_out <= ph ? sum[BPC:1] : cur;  // Odd pixel is the floor average
	end

	assign hs_out = hs_sr[4];
	assign de_out = de_sr[4];

endmodule

//--- hw/scaler_out.sv
/*
	Scaler result stage
	Input registers, scaled or bypass select, output clock enable
*/

`timescale 1ns/1ps

module scaler_out
	import scaler_video_pkg::*;
(
	input  logic           VID_CLK_IN,
	input  logic           rst_n,
	input  logic           run,
	input  logic           vid_cke_in,
	input  logic           vid_vs_in,
	input  logic           vid_hs_in,
	input  logic           vid_de_in,
	input  logic [BPC-1:0] vid_r_in,
	input  logic [BPC-1:0] vid_g_in,
	input  logic [BPC-1:0] vid_b_in,
	input  logic           vs_s,        // Scaled stream
	input  logic           hs_s,
	input  logic           de_s,
	input  logic [BPC-1:0] r_s,
	input  logic [BPC-1:0] g_s,
	input  logic [BPC-1:0] b_s,
	output logic           reg_vs,      // Registered input
	output logic           reg_hs,
	output logic           reg_de,
	output logic [BPC-1:0] reg_r,
	output logic [BPC-1:0] reg_g,
	output logic [BPC-1:0] reg_b,
	output logic           vid_cke_out,
	output logic           vid_vs_out,
	output logic           vid_hs_out,
	output logic           vid_de_out,
	output logic [BPC-1:0] vid_r_out,
	output logic [BPC-1:0] vid_g_out,
	output logic [BPC-1:0] vid_b_out
);

	logic cke_d;  // Input enable, aligned with reg_*

	// Sync and enable as single clock strobes per qualified sample
	always_ff @(posedge VID_CLK_IN or negedge rst_n)
	begin
		if (!rst_n)
		begin
			reg_vs <= 1'b0;
			reg_hs <= 1'b0;
			reg_de <= 1'b0;
			cke_d <= 1'b1;
		end
		else
		begin
			reg_vs <= vid_cke_in & vid_vs_in;
			reg_hs <= vid_cke_in & vid_hs_in;
			reg_de <= vid_cke_in & vid_de_in;
			cke_d <= vid_cke_in;
		end
	end

	// Pixel data held between samples
	always_ff @(posedge VID_CLK_IN)
	begin
		if (vid_cke_in)
		begin
			reg_r <= vid_r_in;
			reg_g <= vid_g_in;
			reg_b <= vid_b_in;
		end
	end

	// Scaled output runs every clock
	assign vid_cke_out = run | cke_d;
	assign vid_vs_out  = run ? vs_s : reg_vs;
	assign vid_hs_out  = run ? hs_s : reg_hs;
	assign vid_de_out  = run ? de_s : reg_de;
	assign vid_r_out   = run ? r_s : reg_r;
	assign vid_g_out   = run ? g_s : reg_g;
	assign vid_b_out   = run ? b_s : reg_b;

endmodule

//--- hw/scaler_reg_pkg.sv
/*
	Scaler register map
	Local bus sizes, register addresses and control bits
*/

package scaler_reg_pkg;

	// Local bus
	localparam int ADR_W = 4;   // Address width
	localparam int DAT_W = 16;  // Data width

	// Register addresses
	localparam int REG_CTL  = 0;  // Control
	localparam int REG_H_IN = 1;  // Input active width
	localparam int REG_V_IN = 2;  // Input active height

	// Control register fields
	localparam int CTL_RUN_BIT = 0;  // Scaler enable

endpackage

//--- hw/scaler_tg.sv
/*
	Scaler output timing generator
	Turns completed input lines into pairs of output lines,
	drives line buffer reads and internal sync
*/

`timescale 1ns/1ps

module scaler_tg
	import scaler_video_pkg::*;
(
	input  logic             VID_CLK_IN,
	input  logic             rst_n,
	input  logic             run,
	input  logic [COL_W-1:0] h_in,
	input  logic [ROW_W-1:0] v_in,
	input  logic             in_vs,      // Input frame start strobe
	input  logic             line_done,  // Input line stored
	output logic             rd_en,
	output logic [COL_W-1:0] rd_col,
	output logic [1:0]       rd_row_a,
	output logic [1:0]       rd_row_b,
	output logic             rd_mix,
	output logic             vs_int,
	output logic             hs_int,
	output logic             de_int
);

	typedef enum logic [2:0] {ST_IDLE, ST_VS, ST_HS, ST_ACT, ST_BLK} st_t;

	st_t              state;
	logic [COL_W:0]   cnt;         // Output pixel or blank count
	logic             pass;        // 0 even line, 1 odd line
	logic [1:0]       pend;        // Line pairs waiting
	logic [1:0]       add;         // Pairs released by this line
	logic [ROW_W-1:0] in_lines;    // Input lines done this frame
	logic [ROW_W-1:0] out_row;     // Row being output
	logic [1:0]       wslot;       // Mirror of buffer write slot
	logic [1:0]       frame_slot;  // Slot of row 0
	logic [1:0]       rd_slot;     // Slot of out_row
	logic             frm;         // Frame in progress
	logic             fst;         // Next pair opens the frame
	logic             last_row;
	logic             pass_end;
	logic             pair_end;

	assign last_row = (out_row == v_in - 1'b1);
	assign pass_end = (state == ST_ACT) && (cnt == {h_in, 1'b0} - 1'b1);
	assign pair_end = pass_end & pass;

	// Line k+1 releases row k, last line also releases itself
	assign add = (frm && line_done) ?
		({1'b0, in_lines != '0} + {1'b0, (in_lines + 1'b1) == v_in}) : 2'd0;

	always_ff @(posedge VID_CLK_IN or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= ST_IDLE;
			cnt <= '0;
			pass <= 1'b0;
			pend <= '0;
			in_lines <= '0;
			out_row <= '0;
			wslot <= '0;
			frame_slot <= '0;
			rd_slot <= '0;
			frm <= 1'b0;
			fst <= 1'b0;
		end
		else
		begin
			if (line_done)
				wslot <= (wslot == LINES - 1) ? 2'd0 : wslot + 2'd1;  // Follows the ring

			if (!run)
			begin
				state <= ST_IDLE;
				pend <= '0;
				pass <= 1'b0;
				frm <= 1'b0;
				fst <= 1'b0;
				in_lines <= '0;
			end
			else
			begin
				if (in_vs)
				begin
					frm <= 1'b1;
					fst <= 1'b1;
					in_lines <= '0;
					frame_slot <= wslot;  // Row 0 lands here
				end
				else if (frm && line_done)
					in_lines <= in_lines + 1'b1;

				pend <= pend + add - {1'b0, pair_end};

				case (state)
					ST_IDLE:
						if (pend != '0)
						begin
							pass <= 1'b0;
							cnt <= '0;
							if (fst)
							begin
								fst <= 1'b0;
								out_row <= '0;
								rd_slot <= frame_slot;
								state <= ST_VS;  // Frame pulse first
							end
							else
								state <= ST_HS;
						end
					ST_VS: state <= ST_HS;
					ST_HS:
					begin
						cnt <= '0;
						state <= ST_ACT;
					end
					ST_ACT:
						if (pass_end)
						begin
							cnt <= '0;
							pass <= ~pass;
							state <= ST_BLK;
							if (pass)
							begin
								out_row <= out_row + 1'b1;
								rd_slot <= (rd_slot == LINES - 1) ? 2'd0 : rd_slot + 2'd1;
							end
						end
						else
							cnt <= cnt + 1'b1;
					ST_BLK:
						if (cnt == H_BLANK - 1)
						begin
							cnt <= '0;
							state <= pass ? ST_HS : ST_IDLE;  // Odd line of the pair follows
						end
						else
							cnt <= cnt + 1'b1;
					default: state <= ST_IDLE;
				endcase
			end
		end
	end

	// Column read every other clock
	assign rd_en    = (state == ST_ACT) && !cnt[0];
	assign rd_col   = cnt[COL_W:1];
	assign rd_row_a = rd_slot;
	assign rd_row_b = (rd_slot == LINES - 1) ? 2'd0 : rd_slot + 2'd1;
	assign rd_mix   = pass && !last_row;  // Last row is repeated
	assign vs_int   = (state == ST_VS);
	assign hs_int   = (state == ST_HS);
	assign de_int   = (state == ST_ACT);

	// No active video while run is off
	a_de_run: assert property (@(posedge VID_CLK_IN) disable iff (!rst_n)
		!run |-> !de_int)
		else $error("de_int active while run cleared");

endmodule

//--- hw/scaler_top.sv
/*
	Bilinear 2x video upscaler
	Register decoder, timing generator, three channel scaler
	and output select with bypass
*/

`timescale 1ns/1ps

module scaler_top
	import scaler_reg_pkg::*, scaler_video_pkg::*;
(
	input  logic             VID_CLK_IN,
	input  logic             rst_n,

	// Local bus
	input  logic             lb_wr,
	input  logic             lb_rd,
	input  logic [ADR_W-1:0] lb_adr,
	input  logic [DAT_W-1:0] lb_din,
	output logic [DAT_W-1:0] lb_dout,
	output logic             lb_vld,

	// Video in
	input  logic             vid_cke_in,
	input  logic             vid_vs_in,
	input  logic             vid_hs_in,
	input  logic             vid_de_in,
	input  logic [BPC-1:0]   vid_r_in,
	input  logic [BPC-1:0]   vid_g_in,
	input  logic [BPC-1:0]   vid_b_in,

	// Video out
	output logic             vid_cke_out,
	output logic             vid_vs_out,
	output logic             vid_hs_out,
	output logic             vid_de_out,
	output logic [BPC-1:0]   vid_r_out,
	output logic [BPC-1:0]   vid_g_out,
	output logic [BPC-1:0]   vid_b_out
);

	logic             run;
	logic [COL_W-1:0] h_in;
	logic [ROW_W-1:0] v_in;

	// Registered input
	logic             reg_vs, reg_hs, reg_de;
	logic [BPC-1:0]   reg_dat [3];  // R, G, B

	// Timing generator
	logic             rd_en, rd_mix;
	logic [COL_W-1:0] rd_col;
	logic [1:0]       rd_row_a, rd_row_b;
	logic             vs_int, hs_int, de_int;

	// Channels
	logic [2:0]       line_done;
	logic [BPC-1:0]   vbs_dat [3];
	logic [2:0]       vbs_vld;
	logic [2:0]       hbs_hs, hbs_de;
	logic [BPC-1:0]   hbs_dat [3];

	scaler_ctl u_ctl (
		.VID_CLK_IN(VID_CLK_IN), .rst_n(rst_n),
		.lb_wr(lb_wr), .lb_rd(lb_rd), .lb_adr(lb_adr), .lb_din(lb_din),
		.lb_dout(lb_dout), .lb_vld(lb_vld),
		.run(run), .h_in(h_in), .v_in(v_in)
	);

	// Paced by channel 0, channels store identically
	scaler_tg u_tg (
		.VID_CLK_IN(VID_CLK_IN), .rst_n(rst_n), .run(run), .h_in(h_in), .v_in(v_in),
		.in_vs(reg_vs), .line_done(line_done[0]),
		.rd_en(rd_en), .rd_col(rd_col), .rd_row_a(rd_row_a), .rd_row_b(rd_row_b),
		.rd_mix(rd_mix), .vs_int(vs_int), .hs_int(hs_int), .de_int(de_int)
	);

	for (genvar i = 0; i < 3; i++)
	begin : gen_ch
		scaler_vbs u_vbs (
			.VID_CLK_IN(VID_CLK_IN), .rst_n(rst_n), .run(run),
			.in_vs(reg_vs), .in_hs(reg_hs), .wr(reg_de), .dat_in(reg_dat[i]),
			.rd_en(rd_en), .rd_col(rd_col), .rd_row_a(rd_row_a), .rd_row_b(rd_row_b),
			.rd_mix(rd_mix), .line_done(line_done[i]), .dat_out(vbs_dat[i]),
			.vld_out(vbs_vld[i])
		);

		scaler_hbs u_hbs (
			.VID_CLK_IN(VID_CLK_IN), .rst_n(rst_n), .run(run), .h_in(h_in),
			.hs_in(hs_int), .de_in(de_int), .dat_in(vbs_dat[i]), .vld_in(vbs_vld[i]),
			.hs_out(hbs_hs[i]), .de_out(hbs_de[i]), .dat_out(hbs_dat[i])
		);
	end

	scaler_out u_out (
		.VID_CLK_IN(VID_CLK_IN), .rst_n(rst_n), .run(run),
		.vid_cke_in(vid_cke_in), .vid_vs_in(vid_vs_in), .vid_hs_in(vid_hs_in),
		.vid_de_in(vid_de_in), .vid_r_in(vid_r_in), .vid_g_in(vid_g_in),
		.vid_b_in(vid_b_in),
		.vs_s(vs_int), .hs_s(hbs_hs[0]), .de_s(hbs_de[0]),
		.r_s(hbs_dat[0]), .g_s(hbs_dat[1]), .b_s(hbs_dat[2]),
		.reg_vs(reg_vs), .reg_hs(reg_hs), .reg_de(reg_de),
		.reg_r(reg_dat[0]), .reg_g(reg_dat[1]), .reg_b(reg_dat[2]),
		.vid_cke_out(vid_cke_out), .vid_vs_out(vid_vs_out), .vid_hs_out(vid_hs_out),
		.vid_de_out(vid_de_out), .vid_r_out(vid_r_out), .vid_g_out(vid_g_out),
		.vid_b_out(vid_b_out)
	);

endmodule

//--- hw/scaler_vbs.sv
/*
	Vertical bilinear scaler, one colour channel
	Ring of line buffers, reads two lines and blends them
*/

`timescale 1ns/1ps

module scaler_vbs
	import scaler_video_pkg::*;
(
	input  logic             VID_CLK_IN,
	input  logic             rst_n,
	input  logic             run,
	input  logic             in_vs,      // Frame start strobe
	input  logic             in_hs,      // Line start strobe
	input  logic             wr,         // Pixel strobe
	input  logic [BPC-1:0]   dat_in,
	input  logic             rd_en,
	input  logic [COL_W-1:0] rd_col,
	input  logic [1:0]       rd_row_a,
	input  logic [1:0]       rd_row_b,
	input  logic             rd_mix,     // Blend both rows
	output logic             line_done,
	output logic [BPC-1:0]   dat_out,
	output logic             vld_out
);

	logic [BPC-1:0]               mem [LINES][MAX_W];  // Line buffers
	logic [1:0]                   wslot;               // Slot being written
	logic [COL_W-1:0]             wcol;                // Write column
	logic [$clog2(H_BLANK)-1:0]   idle;                // Clocks since last pixel
	logic                         open;                // Line has pixels
	logic                         wr_q;                // Qualified write
	logic [BPC-1:0]               pix_a;
	logic [BPC-1:0]               pix_b;
	logic [BPC:0]                 sum;                 // Carry kept for average

	assign wr_q = run & wr;

	// Line store
	always_ff @(posedge VID_CLK_IN)
	begin
		if (wr_q)
			mem[wslot][wcol[COL_W-2:0]] <= dat_in;
	end

	// Write side control
	always_ff @(posedge VID_CLK_IN or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wslot <= '0;
			wcol <= '0;
			idle <= '0;
			open <= 1'b0;
			line_done <= 1'b0;
		end
		else
		begin
			line_done <= 1'b0;
			if (!run)
			begin
				wcol <= '0;
				idle <= '0;
				open <= 1'b0;
			end
			else if (wr_q)
			begin
				wcol <= wcol + 1'b1;
				idle <= '0;
				open <= 1'b1;
			end
			else if (open)
			begin
				// Line closes after H_BLANK clocks without a pixel
				if (idle == H_BLANK - 1)
				begin
					open <= 1'b0;
					wcol <= '0;
					line_done <= 1'b1;
					wslot <= (wslot == LINES - 1) ? 2'd0 : wslot + 2'd1;
				end
				else
					idle <= idle + 1'b1;
			end
			else if (in_vs || in_hs)
				wcol <= '0;  // Realign at sync
		end
	end

	// Read and blend
	assign pix_a = mem[rd_row_a][rd_col[COL_W-2:0]];
	assign pix_b = mem[rd_row_b][rd_col[COL_W-2:0]];
	assign sum   = {1'b0, pix_a} + {1'b0, pix_b};

	always_ff @(posedge VID_CLK_IN)
	begin
		if (rd_en)
			dat_out <= rd_mix ? sum[BPC:1] : pix_a;  // Floor average
	end

	always_ff @(posedge VID_CLK_IN or negedge rst_n)
	begin
		if (!rst_n)
			vld_out <= 1'b0;
		else
			vld_out <= rd_en;  // Data one clock after request
	end

	// Input line wider than buffer
	a_wcol: assert property (@(posedge VID_CLK_IN) disable iff (!rst_n)
		wr_q |-> wcol < MAX_W)
		else $error("write column overflow, wcol=%0h", wcol);

endmodule

//--- hw/scaler_video_pkg.sv
/*
	Scaler video definitions
	Pixel format, line buffer sizing and output blanking
*/

package scaler_video_pkg;

	// Pixel format
	localparam int BPC = 8;                    // Bits per component

	// Frame limits
	localparam int MAX_W = 64;                 // Max input active width
	localparam int MAX_H = 64;                 // Max input active height
	localparam int COL_W = $clog2(MAX_W) + 1;  // Column index, holds MAX_W itself
	localparam int ROW_W = $clog2(MAX_H) + 1;  // Row count, holds MAX_H itself

	// Output timing
	localparam int H_BLANK = 8;                // Idle clocks between output lines

	// Line buffer ring
	localparam int LINES = 3;                  // Two lines read while a third fills

endpackage

//--- list.f
hw/scaler_video_pkg.sv
hw/scaler_reg_pkg.sv
hw/scaler_ctl.sv
hw/scaler_tg.sv
hw/scaler_vbs.sv
hw/scaler_hbs.sv
hw/scaler_out.sv
hw/scaler_top.sv
testbench/tb_scaler.sv

//--- testbench/tb_scaler.sv
/*
	Testbench for the 2x bilinear video upscaler
	Drives the register bus and video frames, checks bypass and scaled output
*/

`timescale 1ns/1ps

module tb_scaler
	import scaler_reg_pkg::*, scaler_video_pkg::*;
();

	logic             VID_CLK_IN;
	logic             rst_n;
	logic             lb_wr;
	logic             lb_rd;
	logic [ADR_W-1:0] lb_adr;
	logic [DAT_W-1:0] lb_din;
	logic [DAT_W-1:0] lb_dout;
	logic             lb_vld;
	logic             vid_cke_in;
	logic             vid_vs_in;
	logic             vid_hs_in;
	logic             vid_de_in;
	logic [BPC-1:0]   vid_r_in;
	logic [BPC-1:0]   vid_g_in;
	logic [BPC-1:0]   vid_b_in;
	logic             vid_cke_out;
	logic             vid_vs_out;
	logic             vid_hs_out;
	logic             vid_de_out;
	logic [BPC-1:0]   vid_r_out;
	logic [BPC-1:0]   vid_g_out;
	logic [BPC-1:0]   vid_b_out;

	logic [BPC-1:0]   pix [3][MAX_H][MAX_W];  // Input frame, R G B planes
	logic [3*BPC+2:0] exp_q [$];              // Expected {vs, hs, de, rgb} events
	logic [3*BPC+2:0] got_q [$];              // Collected output events
	logic [31:0]      lcg_state;
	logic             scaled;                 // Output expected from scaler
	logic             de_prev;
	int               line_pix;               // Pixels seen in current output line
	logic             failed;
	logic             run_model;              // Expected run bit
	logic             cke_prev;               // Input enable one clock back

	scaler_top u_dut (
		.VID_CLK_IN(VID_CLK_IN), .rst_n(rst_n),
		.lb_wr(lb_wr), .lb_rd(lb_rd), .lb_adr(lb_adr), .lb_din(lb_din),
		.lb_dout(lb_dout), .lb_vld(lb_vld),
		.vid_cke_in(vid_cke_in), .vid_vs_in(vid_vs_in), .vid_hs_in(vid_hs_in),
		.vid_de_in(vid_de_in), .vid_r_in(vid_r_in), .vid_g_in(vid_g_in), .vid_b_in(vid_b_in),
		.vid_cke_out(vid_cke_out), .vid_vs_out(vid_vs_out), .vid_hs_out(vid_hs_out),
		.vid_de_out(vid_de_out), .vid_r_out(vid_r_out), .vid_g_out(vid_g_out),
		.vid_b_out(vid_b_out)
	);

	initial
	begin
		VID_CLK_IN = 1'b0;
		forever #2 VID_CLK_IN = ~VID_CLK_IN;  // 4 ns period
	end

	task automatic fail_stop(input string why);
		failed = 1'b1;
		$display("%s", why);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else
			fail_stop($sformatf("ERR %s got %h expected %h", name, got, exp));
	endtask

	// Pseudo random byte
	function automatic logic [BPC-1:0] lcg_byte();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[23:16];  // Upper bits, better period
	endfunction

	// Sync flags plus colour, colour ignored outside active video
	function automatic logic [3*BPC+2:0] pack_ev(input logic vs, input logic hs, input logic de,
			input logic [BPC-1:0] r, input logic [BPC-1:0] g, input logic [BPC-1:0] b);
		if (de)
			return {vs, hs, de, r, g, b};
		else
			return {vs, hs, de, {(3*BPC){1'b0}}};
	endfunction

	// Run bit and input enable as the DUT sees them at this edge
	always @(posedge VID_CLK_IN)
	begin
		if (!rst_n)
		begin
			run_model <= 1'b0;
			cke_prev  <= 1'b1;
		end
		else
		begin
			if (lb_wr && lb_adr == ADR_W'(REG_CTL))
				run_model <= lb_din[CTL_RUN_BIT];  // Write lands on this clock
			cke_prev <= vid_cke_in;
		end
	end

	// Output collector, outputs come from registers so negedge is stable
	always @(negedge VID_CLK_IN)
	begin
		if (rst_n)
			check_val("vid_cke_out", vid_cke_out, run_model | cke_prev);  // Every clock when scaling
		if (rst_n && vid_cke_out)
		begin
			if (vid_vs_out || vid_hs_out || vid_de_out)
				got_q.push_back(pack_ev(vid_vs_out, vid_hs_out, vid_de_out,
					vid_r_out, vid_g_out, vid_b_out));
			if (vid_hs_out)
				line_pix = 0;
			if (scaled && vid_de_out)
			begin
				assert (de_prev || line_pix == 0)
				else
					fail_stop("active pixels of an output line are not on consecutive clocks");
				line_pix++;
			end
			de_prev = vid_de_out;
		end
	end

	task automatic bus_write(input int adr, input int dat);
		@(negedge VID_CLK_IN);
		lb_wr  = 1'b1;
		lb_adr = ADR_W'(adr);
		lb_din = DAT_W'(dat);
		@(negedge VID_CLK_IN);
		lb_wr  = 1'b0;
	endtask

	// Read strobe, data and valid exactly one clock later
	task automatic bus_read_check(input int adr, input int exp, input string name);
		@(negedge VID_CLK_IN);
		check_val("lb_vld before read", lb_vld, 32'd0);
		lb_rd  = 1'b1;
		lb_adr = ADR_W'(adr);
		@(negedge VID_CLK_IN);
		lb_rd  = 1'b0;
		check_val("lb_vld", lb_vld, 32'd1);
		check_val(name, lb_dout, exp);
		@(negedge VID_CLK_IN);
		check_val("lb_vld after read", lb_vld, 32'd0);  // Single clock pulse
	endtask

	// One qualified sample every 4 clocks
	task automatic drive_sample(input logic vs, input logic hs, input logic de,
			input logic [BPC-1:0] r, input logic [BPC-1:0] g, input logic [BPC-1:0] b,
			input logic keep);
		@(negedge VID_CLK_IN);
		vid_cke_in = 1'b1;
		vid_vs_in  = vs;
		vid_hs_in  = hs;
		vid_de_in  = de;
		vid_r_in   = r;
		vid_g_in   = g;
		vid_b_in   = b;
		if (keep && (vs || hs || de))
			exp_q.push_back(pack_ev(vs, hs, de, r, g, b));  // Bypass expectation
		@(negedge VID_CLK_IN);
		vid_cke_in = 1'b0;
		vid_vs_in  = 1'b0;
		vid_hs_in  = 1'b0;
		vid_de_in  = 1'b0;
		repeat (2) @(negedge VID_CLK_IN);
	endtask

	task automatic drive_frame(input int w, input int h, input logic keep);
		int x;
		int y;
		int blank;
		blank = 2 * H_BLANK / 4 + 2;  // Line period 4w + 2*H_BLANK + 12
		drive_sample(1'b1, 1'b0, 1'b0, '0, '0, '0, keep);
		for (y = 0; y < h; y++)
		begin
			drive_sample(1'b0, 1'b1, 1'b0, '0, '0, '0, keep);
			for (x = 0; x < w; x++)
				drive_sample(1'b0, 1'b0, 1'b1, pix[0][y][x], pix[1][y][x], pix[2][y][x], keep);
			repeat (blank) drive_sample(1'b0, 1'b0, 1'b0, '0, '0, '0, keep);
		end
	endtask

	task automatic fill_ramp(input int w, input int h);
		int x;
		int y;
		for (y = 0; y < h; y++)
			for (x = 0; x < w; x++)
			begin
				pix[0][y][x] = BPC'(y * 40 + x * 9);
				pix[1][y][x] = BPC'(x * 25 + y * 3 + 1);
				pix[2][y][x] = BPC'(250 - y * 50 - x * 7);  // Falling ramp
			end
	endtask

	task automatic fill_random(input int w, input int h);
		int c;
		int x;
		int y;
		for (c = 0; c < 3; c++)
			for (y = 0; y < h; y++)
				for (x = 0; x < w; x++)
					pix[c][y][x] = lcg_byte();
	endtask

	// Even output line copies row k, odd averages rows k and k+1, last row repeated
	function automatic int vert_pix(input int ch, input int ol, input int c, input int h);
		int k;
		k = ol / 2;
		if (ol % 2 == 0 || k == h - 1)
			return int'(pix[ch][k][c]);
		else
			return (int'(pix[ch][k][c]) + int'(pix[ch][k + 1][c])) / 2;
	endfunction

	// Same rule across columns, last column repeated
	function automatic int scaled_pix(input int ch, input int ol, input int oc,
			input int w, input int h);
		int c;
		c = oc / 2;
		if (oc % 2 == 0 || c == w - 1)
			return vert_pix(ch, ol, c, h);
		else
			return (vert_pix(ch, ol, c, h) + vert_pix(ch, ol, c + 1, h)) / 2;
	endfunction

	task automatic expect_scaled(input int w, input int h);
		int ol;
		int oc;
		exp_q.push_back(pack_ev(1'b1, 1'b0, 1'b0, '0, '0, '0));  // One frame pulse
		for (ol = 0; ol < 2 * h; ol++)
		begin
			exp_q.push_back(pack_ev(1'b0, 1'b1, 1'b0, '0, '0, '0));
			for (oc = 0; oc < 2 * w; oc++)
				exp_q.push_back(pack_ev(1'b0, 1'b0, 1'b1, BPC'(scaled_pix(0, ol, oc, w, h)),
					BPC'(scaled_pix(1, ol, oc, w, h)), BPC'(scaled_pix(2, ol, oc, w, h))));
		end
	endtask

	task automatic start_check();
		got_q.delete();
		exp_q.delete();
		line_pix = 0;
		de_prev  = 1'b0;
	endtask

	task automatic wait_and_compare(input string what);
		int t;
		int i;
		t = 0;
		while (got_q.size() < exp_q.size() && t < 4000)
		begin
			@(negedge VID_CLK_IN);
			t++;
		end
		assert (got_q.size() >= exp_q.size())
		else
			fail_stop($sformatf("timeout waiting for %s output", what));
		repeat (40) @(negedge VID_CLK_IN);  // Trailing events would show up here
		check_val("output event count", got_q.size(), exp_q.size());
		for (i = 0; i < exp_q.size(); i++)
			check_val($sformatf("{vid_vs_out,vid_hs_out,vid_de_out,r,g,b} event %0d", i),
				got_q[i], exp_q[i]);
	endtask

	task automatic test_reset_state();
		check_val("vid_de_out", vid_de_out, 32'd0);
		check_val("vid_vs_out", vid_vs_out, 32'd0);
		check_val("vid_hs_out", vid_hs_out, 32'd0);
		check_val("vid_cke_out", vid_cke_out, 32'd1);
		check_val("lb_vld", lb_vld, 32'd0);
		rst_n = 1'b1;
		bus_read_check(REG_CTL, 0, "lb_dout run");
		bus_read_check(5, 0, "lb_dout unmapped");
	endtask

	task automatic test_registers();
		bus_write(REG_H_IN, 0);
		bus_read_check(REG_H_IN, 1, "lb_dout h_in");           // Low clamp
		bus_write(REG_H_IN, 100);
		bus_read_check(REG_H_IN, MAX_W, "lb_dout h_in");
		bus_write(REG_H_IN, 6);
		bus_read_check(REG_H_IN, 6, "lb_dout h_in");
		bus_write(REG_V_IN, 0);
		bus_read_check(REG_V_IN, 1, "lb_dout v_in");
		bus_write(REG_V_IN, 1000);
		bus_read_check(REG_V_IN, MAX_H, "lb_dout v_in");       // High clamp
		bus_write(REG_V_IN, 4);
		bus_read_check(REG_V_IN, 4, "lb_dout v_in");
	endtask

	task automatic test_bypass();
		start_check();
		fill_random(5, 3);
		drive_frame(5, 3, 1'b1);
		wait_and_compare("bypass");
	endtask

	task automatic test_ramp_scaling();
		bus_write(REG_H_IN, 6);
		bus_write(REG_V_IN, 4);
		bus_write(REG_CTL, 1 << CTL_RUN_BIT);
		bus_read_check(REG_CTL, 1, "lb_dout run");
		scaled = 1'b1;
		start_check();
		fill_ramp(6, 4);
		expect_scaled(6, 4);  // 8 lines of 12
		drive_frame(6, 4, 1'b0);
		wait_and_compare("ramp scaled");
	endtask

	task automatic test_random_scaling();
		bus_write(REG_H_IN, 16);
		bus_write(REG_V_IN, 5);
		start_check();
		fill_random(16, 5);
		expect_scaled(16, 5);
		drive_frame(16, 5, 1'b0);
		wait_and_compare("random scaled");
	endtask

	task automatic test_back_to_bypass();
		bus_write(REG_CTL, 0);
		bus_read_check(REG_CTL, 0, "lb_dout run");
		scaled = 1'b0;
		start_check();
		fill_random(7, 2);
		drive_frame(7, 2, 1'b1);
		wait_and_compare("second bypass");
	endtask

	initial
	begin
		lb_wr      = 1'b0;
		lb_rd      = 1'b0;
		lb_adr     = '0;
		lb_din     = '0;
		vid_cke_in = 1'b0;
		vid_vs_in  = 1'b0;
		vid_hs_in  = 1'b0;
		vid_de_in  = 1'b0;
		vid_r_in   = '0;
		vid_g_in   = '0;
		vid_b_in   = '0;
		lcg_state  = 32'hced1;
		scaled     = 1'b0;
		de_prev    = 1'b0;
		line_pix   = 0;
		failed     = 1'b0;
		rst_n      = 1'b0;
		repeat (3) @(negedge VID_CLK_IN);  // Reset for 3 cycles
		test_reset_state();
		test_registers();
		test_bypass();
		test_ramp_scaling();
		test_random_scaling();
		test_back_to_bypass();
		if (!failed)
		begin
			$display("Everything OK");
			$finish;
		end
		else
			fail_stop("one or more checks did not match");
	end

endmodule
